// ==== vlog.f ====
+incdir+.
core_pkg.sv
alu.sv
reg_file.sv
mem_arbiter.sv
instr_fetch.sv
load_store.sv
core_ctrl.sv
core_top.sv
core_tb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench
TOP := core_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== core_tb.sv ====
`include "core_cfg.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                      TIMEOUT   = 2000;     // Cycles allowed to reach HALT
    localparam logic [`CORE_DATA_W-1:0] DUMP_BASE = 16'h00E0; // r0..r15 land here

    logic                    clk        = 1'b0;
    logic                    arst_n;
    logic                    mem_req;
    core_pkg::mem_req_t      mem_out;
    logic [`CORE_DATA_W-1:0] mem_rdata  = '0;
    logic                    mem_rvalid = 1'b0;
    logic                    halted;

    logic [`CORE_DATA_W-1:0] mem [256];                 // Memory model indexed by addr[7:0]
    logic [7:0]              rd_addr    = '0;
    logic                    rd_due     = 1'b0;         // Answer due after the next edge

    // Shadow machine state
    logic [`CORE_DATA_W-1:0] sh_regs [16];
    logic [`CORE_DATA_W-1:0] sh_mem [256];
    core_pkg::flags_t        sh_flags;
    core_pkg::instr_t        prog [$];
    core_pkg::mem_req_t      exp_q [$];                 // Stores still due on the bus
    string                   test_name;
    integer                  seed;

    core_top dut0 (.clk, .arst_n, .mem_req, .mem_out, .mem_rdata, .mem_rvalid, .halted);

    always #4 clk = ~clk;                               // 8 ns period

    ////////////////////////////////////////////////////////////
    // Error reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic halt_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        if (act !== exp)
            halt_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    // Shown as addr/we/wdata
    task automatic check_mem_req(input string name, input core_pkg::mem_req_t exp,
                                 input core_pkg::mem_req_t act);
        if (act !== exp)
            halt_on_error($sformatf("Fail %s expected %h/%b/%h actual %h/%b/%h", name,
                exp.addr, exp.we, exp.wdata, act.addr, act.we, act.wdata));
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic void model_step(input core_pkg::instr_t ins);
        logic [7:0]         imm;
        logic [15:0]        a;
        logic [15:0]        b;
        logic [16:0]        wide;
        logic               ovf;
        int                 mode;                       // 1 signed, 2 unsigned, 3 with carry
        core_pkg::mem_req_t st;
        imm  = {ins.opext, ins.rsrc};
        a    = sh_regs[ins.rdest];
        b    = sh_regs[ins.rsrc];
        mode = 0;
        case (ins.opcode)
            core_pkg::OP_ADDGRP:
            begin
                if (ins.opext == core_pkg::EXT_ADD)
                    mode = 1;
                else if (ins.opext == core_pkg::EXT_ADDU)
                    mode = 2;
                else if (ins.opext == core_pkg::EXT_ADDC)
                    mode = 3;                           // WAIT leaves mode 0
            end
            core_pkg::OP_ADDI:
            begin
                b    = {{8{imm[7]}}, imm};              // Sign-extended
                mode = 1;
            end
            core_pkg::OP_ADDUI:
            begin
                b    = {8'h00, imm};
                mode = 2;
            end
            core_pkg::OP_ADDCI:
            begin
                b    = {{8{imm[7]}}, imm};
                mode = 3;
            end
            core_pkg::OP_MOVI: sh_regs[ins.rdest] = {8'h00, imm};   // Flags untouched
            core_pkg::OP_LOADSTOR:
            begin
                if (ins.opext == core_pkg::EXT_STOR)
                begin
                    sh_mem[b[7:0]] = a;                 // rdest to [rsrc]
                    st.addr  = b;
                    st.we    = 1'b1;
                    st.wdata = a;
                    exp_q.push_back(st);
                end
                else
                    sh_regs[ins.rdest] = sh_mem[b[7:0]];
            end
            default: ;
        endcase
        if (mode != 0)
        begin
            wide = {1'b0, a} + {1'b0, b} + {16'h0000, (mode == 3) & sh_flags.c};
            ovf  = (a[15] == b[15]) && (wide[15] != a[15]);  // Like signs and a flipped sign
            sh_regs[ins.rdest] = wide[15:0];
            sh_flags   = '0;
            sh_flags.c = (mode != 1) && wide[16];
            sh_flags.f = (mode != 2) && ovf;
            sh_flags.z = (wide[15:0] == 16'h0000);
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Program building
    ////////////////////////////////////////////////////////////

    function automatic void reg_op(input core_pkg::opext_e ext, input logic [3:0] rd,
                                   input logic [3:0] rs);
        prog.push_back(core_pkg::instr_t'({core_pkg::OP_ADDGRP, rd, ext, rs}));
    endfunction

    function automatic void imm_op(input core_pkg::opcode_e op, input logic [3:0] rd,
                                   input logic [7:0] imm);
        prog.push_back(core_pkg::instr_t'({op, rd, imm}));
    endfunction

    function automatic void mem_op(input logic store, input logic [3:0] rd,
                                   input logic [3:0] rs);
        core_pkg::opext_e ext;
        if (store)
            ext = core_pkg::EXT_STOR;
        else
            ext = core_pkg::EXT_LOAD;
        prog.push_back(core_pkg::instr_t'({core_pkg::OP_LOADSTOR, rd, ext, rs}));
    endfunction

    // r15 addresses r0..r14 and r14 addresses r15
    function automatic void dump_regs();
        for (int i = 0; i < 15; i++)
        begin
            imm_op(core_pkg::OP_MOVI, 4'd15, DUMP_BASE[7:0] + 8'(i));
            mem_op(1'b1, 4'(i), 4'd15);
        end
        imm_op(core_pkg::OP_MOVI, 4'd14, DUMP_BASE[7:0] + 8'd15);
        mem_op(1'b1, 4'd15, 4'd14);
        reg_op(core_pkg::EXT_WAIT, 4'd0, 4'd0);
    endfunction

    function automatic logic [15:0] fill_word(input int addr);
        return {8'(addr) ^ 8'hC3, 8'(addr)};
    endfunction

    task automatic run_program(input string name);
        int cycles;
        test_name = name;
        @(posedge clk);
        #1 arst_n = 1'b0;
        if (prog.size() > int'(DUMP_BASE))
            halt_on_error({name, " program runs into the register dump area"});
        foreach (prog[i])
            mem[8'(`CORE_RESET_PC + i)] = prog[i];
        sh_mem = mem;
        for (int i = 0; i < 16; i++)
            sh_regs[i] = '0;
        sh_flags = '0;
        exp_q.delete();
        foreach (prog[i])
            model_step(prog[i]);
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
        check_word({name, " halted after reset"}, 16'h0000, {15'h0000, halted});
        cycles = 0;
        while (halted !== 1'b1)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                halt_on_error({name, " timed out, the core never halted"});
        end
        check_word({name, " stores missing"}, 16'h0000, 16'(exp_q.size()));
        for (int i = 0; i < 20; i++)                   // Quiet window after WAIT
        begin
            @(negedge clk);
            if (halted !== 1'b1)
                halt_on_error({name, " halted dropped after WAIT"});
            if (mem_req !== 1'b0)
                halt_on_error({name, " memory request after WAIT"});
        end
        prog.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model and store compare
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        #1;
        mem_rvalid = rd_due;                            // Exactly one cycle after the strobe
        mem_rdata  = rd_due ? mem[rd_addr] : 16'h0000;
        rd_due     = 1'b0;
        @(negedge clk);                                 // Request stable mid-cycle
        if (arst_n && mem_req)
        begin
            if (mem_out.we)
            begin
                if (exp_q.size() == 0)
                    halt_on_error({test_name, " store on the bus with none expected"});
                else
                    check_mem_req(test_name, exp_q.pop_front(), mem_out);
                mem[mem_out.addr[7:0]] = mem_out.wdata;
            end
            else
            begin
                rd_addr = mem_out.addr[7:0];
                rd_due  = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] r;
        arst_n     = 1'b0;
        seed       = 32'he50a_36b1;
        for (int i = 0; i < 256; i++)
            mem[i] = fill_word(i);

        // MOVI then STOR
        for (int i = 0; i < 15; i++)
            imm_op(core_pkg::OP_MOVI, 4'(i), 8'(8'h0F + i * 8'h11));
        imm_op(core_pkg::OP_MOVI, 4'd15, 8'h70);
        mem_op(1'b1, 4'd3, 4'd15);
        mem_op(1'b1, 4'd14, 4'd15);                     // Same address so the second wins
        dump_regs();
        run_program("movi_stor");

        // Signed adds and wraparound
        imm_op(core_pkg::OP_MOVI, 4'd1, 8'h40);
        for (int i = 0; i < 9; i++)
            reg_op(core_pkg::EXT_ADD, 4'd1, 4'd1);      // Doubles up to 0x8000
        imm_op(core_pkg::OP_ADDI, 4'd2, 8'h80);         // -128
        imm_op(core_pkg::OP_ADDI, 4'd2, 8'h7F);         // -1
        reg_op(core_pkg::EXT_ADD, 4'd3, 4'd1);
        reg_op(core_pkg::EXT_ADD, 4'd3, 4'd2);          // 0x8000 + 0xFFFF wraps
        imm_op(core_pkg::OP_ADDI, 4'd3, 8'h01);
        imm_op(core_pkg::OP_MOVI, 4'd4, 8'h7F);
        imm_op(core_pkg::OP_ADDI, 4'd4, 8'h81);         // Back to zero
        reg_op(core_pkg::EXT_ADD, 4'd5, 4'd2);
        reg_op(core_pkg::EXT_ADD, 4'd5, 4'd2);
        dump_regs();
        run_program("add_signed");

        // Carry out feeding the next add
        imm_op(core_pkg::OP_ADDI, 4'd1, 8'hFF);         // 0xFFFF
        imm_op(core_pkg::OP_MOVI, 4'd2, 8'h01);
        reg_op(core_pkg::EXT_ADDU, 4'd1, 4'd2);         // Carries out
        imm_op(core_pkg::OP_MOVI, 4'd3, 8'h10);         // MOVI keeps C
        imm_op(core_pkg::OP_MOVI, 4'd4, 8'h20);
        reg_op(core_pkg::EXT_ADDC, 4'd3, 4'd4);
        imm_op(core_pkg::OP_ADDI, 4'd5, 8'hF0);
        imm_op(core_pkg::OP_ADDUI, 4'd5, 8'h20);        // 0xFFF0 + 0x20 carries
        imm_op(core_pkg::OP_MOVI, 4'd6, 8'h05);
        imm_op(core_pkg::OP_ADDCI, 4'd6, 8'h03);
        imm_op(core_pkg::OP_ADDCI, 4'd6, 8'hFF);        // Minus one carries out
        reg_op(core_pkg::EXT_ADDC, 4'd7, 4'd7);
        dump_regs();
        run_program("carry_chain");

        // LOAD from preloaded words
        for (int k = 0; k < 8; k++)
        begin
            mem[8'hA0 + 8'(k)] = 16'hBEEF ^ 16'(k * 16'h1357);
            imm_op(core_pkg::OP_MOVI, 4'd8, 8'hA0 + 8'(k));
            mem_op(1'b0, 4'(k), 4'd8);
        end
        reg_op(core_pkg::EXT_ADD, 4'd0, 4'd1);
        imm_op(core_pkg::OP_MOVI, 4'd10, 8'hA7);
        mem_op(1'b0, 4'd10, 4'd10);                     // Address reg overwritten by its load
        dump_regs();
        run_program("load_store");

        // Random adds, MOVI and LOAD
        for (int i = 0; i < 40; i++)
        begin
            r = $random(seed);
            case (r[18:16])
                3'd0: reg_op(core_pkg::EXT_ADD, r[3:0], r[7:4]);
                3'd1: reg_op(core_pkg::EXT_ADDU, r[3:0], r[7:4]);
                3'd2: reg_op(core_pkg::EXT_ADDC, r[3:0], r[7:4]);
                3'd3: imm_op(core_pkg::OP_ADDI, r[3:0], r[15:8]);
                3'd4: imm_op(core_pkg::OP_ADDUI, r[3:0], r[15:8]);
                3'd5: imm_op(core_pkg::OP_ADDCI, r[3:0], r[15:8]);
                3'd6: imm_op(core_pkg::OP_MOVI, r[3:0], r[15:8]);
                default: mem_op(1'b0, r[3:0], r[7:4]);
            endcase
        end
        dump_regs();
        run_program("random_program");

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== core_top.sv ====
`include "core_cfg.svh"

module core_top (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    mem_req,
    output core_pkg::mem_req_t      mem_out,
    input  logic [`CORE_DATA_W-1:0] mem_rdata,
    input  logic                    mem_rvalid,
    output logic                    halted
);

    // Fetch path
    logic                    fetch_start, fetch_req, fetch_gnt, fetch_rvalid;
    logic [`CORE_DATA_W-1:0] fetch_addr;
    logic                    instr_valid;
    core_pkg::instr_t        instr;
    // Load/store path
    logic                    ls_start, ls_we, ls_req, ls_gnt, ls_rvalid, ls_done;
    logic [`CORE_DATA_W-1:0] ls_addr, ls_wdata, ls_rdata, rdata;
    core_pkg::mem_req_t      ls_cmd;
    // Register file and ALU
    logic [3:0]              ra_addr, rb_addr, rf_waddr;
    logic [`CORE_DATA_W-1:0] ra_data, rb_data, rf_wdata;
    logic                    rf_we;
    logic [`CORE_DATA_W-1:0] alu_a, alu_b, alu_result;
    core_pkg::opcode_e       alu_opcode;
    core_pkg::opext_e        alu_opext;
    logic                    alu_carry;
    core_pkg::flags_t        alu_flags;

    alu u_alu (.a(alu_a), .b(alu_b), .opcode(alu_opcode), .opext(alu_opext),
        .carry(alu_carry), .result(alu_result), .flags(alu_flags));

    reg_file u_reg_file (.clk, .arst_n, .ra_addr, .rb_addr, .ra_data, .rb_data,
        .we(rf_we), .w_addr(rf_waddr), .w_data(rf_wdata));

    mem_arbiter u_mem_arbiter (.clk, .arst_n, .fetch_req, .fetch_addr, .fetch_gnt,
        .fetch_rvalid, .ls_req, .ls_cmd, .ls_gnt, .ls_rvalid, .rdata,
        .mem_req, .mem_out, .mem_rdata, .mem_rvalid);

    instr_fetch u_instr_fetch (.clk, .arst_n, .fetch_start, .fetch_req, .fetch_addr,
        .fetch_gnt, .fetch_rvalid, .rdata, .instr_valid, .instr);

    load_store u_load_store (.clk, .arst_n, .ls_start, .ls_we, .ls_addr, .ls_wdata,
        .ls_req, .ls_cmd, .ls_gnt, .ls_rvalid, .rdata, .ls_done, .ls_rdata);

    core_ctrl u_core_ctrl (.clk, .arst_n, .fetch_start, .instr_valid, .instr,
        .ls_start, .ls_we, .ls_addr, .ls_wdata, .ls_done, .ls_rdata,
        .ra_addr, .rb_addr, .ra_data, .rb_data, .rf_we, .rf_waddr, .rf_wdata,
        .alu_a, .alu_b, .alu_opcode, .alu_opext, .alu_carry, .alu_result,
        .alu_flags, .halted);

endmodule

// ==== core_ctrl.sv ====
`include "core_cfg.svh"

module core_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    // Fetch unit
    output logic                    fetch_start,
    input  logic                    instr_valid,
    input  core_pkg::instr_t        instr,
    // Load/store unit
    output logic                    ls_start,
    output logic                    ls_we,
    output logic [`CORE_DATA_W-1:0] ls_addr,
    output logic [`CORE_DATA_W-1:0] ls_wdata,
    input  logic                    ls_done,
    input  logic [`CORE_DATA_W-1:0] ls_rdata,
    // Register file
    output logic [3:0]              ra_addr,
    output logic [3:0]              rb_addr,
    input  logic [`CORE_DATA_W-1:0] ra_data,
    input  logic [`CORE_DATA_W-1:0] rb_data,
    output logic                    rf_we,
    output logic [3:0]              rf_waddr,
    output logic [`CORE_DATA_W-1:0] rf_wdata,
    // ALU
    output logic [`CORE_DATA_W-1:0] alu_a,
    output logic [`CORE_DATA_W-1:0] alu_b,
    output core_pkg::opcode_e       alu_opcode,
    output core_pkg::opext_e        alu_opext,
    output logic                    alu_carry,
    input  logic [`CORE_DATA_W-1:0] alu_result,
    input  core_pkg::flags_t        alu_flags,
    output logic                    halted
);

    core_pkg::ctrl_state_e   state;
    core_pkg::ctrl_state_e   state_n;
    core_pkg::flags_t        flags_q;         // Status register
    logic                    fetch_busy;      // Fetch launched, word not back
    logic                    fetch_busy_n;
    logic [`CORE_IMM_W-1:0]  imm;
    logic [`CORE_DATA_W-1:0] imm_ext;
    logic                    reg_form;
    logic                    is_add;
    logic                    is_movi;
    logic                    is_load;
    logic                    is_stor;
    logic                    is_wait;

    ////////////////////////////////////////////////////////////
    // Decode and operands
    ////////////////////////////////////////////////////////////

    assign reg_form = (instr.opcode == core_pkg::OP_ADDGRP);
    assign is_add   = (reg_form && (instr.opext inside {core_pkg::EXT_ADD,
                                                        core_pkg::EXT_ADDU,
                                                        core_pkg::EXT_ADDC}))
                   || (instr.opcode inside {core_pkg::OP_ADDI,
                                            core_pkg::OP_ADDUI,
                                            core_pkg::OP_ADDCI});
    assign is_movi  = (instr.opcode == core_pkg::OP_MOVI);
    assign is_load  = (instr.opcode == core_pkg::OP_LOADSTOR)
                   && (instr.opext == core_pkg::EXT_LOAD);
    assign is_stor  = (instr.opcode == core_pkg::OP_LOADSTOR)
                   && (instr.opext == core_pkg::EXT_STOR);
    assign is_wait  = reg_form && (instr.opext == core_pkg::EXT_WAIT);

    // Signed immediates for ADDI/ADDCI, zero-extended otherwise
    assign imm     = {instr.opext, instr.rsrc};
    assign imm_ext = (instr.opcode inside {core_pkg::OP_ADDI, core_pkg::OP_ADDCI})
                   ? {{(`CORE_DATA_W-`CORE_IMM_W){imm[`CORE_IMM_W-1]}}, imm}
                   : {{(`CORE_DATA_W-`CORE_IMM_W){1'b0}}, imm};

    assign ra_addr    = instr.rdest;
    assign rb_addr    = instr.rsrc;
    assign alu_a      = ra_data;
    assign alu_b      = reg_form ? rb_data : imm_ext;
    assign alu_opcode = instr.opcode;
    assign alu_opext  = instr.opext;
    assign alu_carry  = flags_q.c;

    // STOR puts rdest at [rsrc], LOAD reads [rsrc]
    assign ls_start = (state == core_pkg::S_EXEC) && (is_load || is_stor);
    assign ls_we    = is_stor;
    assign ls_addr  = rb_data;
    assign ls_wdata = ra_data;

    ////////////////////////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////////////////////////

    assign rf_we    = ((state == core_pkg::S_EXEC) && (is_add || is_movi))
                   || ((state == core_pkg::S_MEM) && ls_done && is_load);
    assign rf_waddr = instr.rdest;

    always_comb
    begin
        if (state == core_pkg::S_MEM)
            rf_wdata = ls_rdata;              // LOAD
        else if (is_movi)
            rf_wdata = imm_ext;
        else
            rf_wdata = alu_result;
    end

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_n = state;
        case (state)
            core_pkg::S_FETCH: if (instr_valid) state_n = core_pkg::S_EXEC;
            core_pkg::S_EXEC:
            begin
                if (is_load || is_stor)
                    state_n = core_pkg::S_MEM;
                else if (is_wait)
                    state_n = core_pkg::S_HALT;
                else
                    state_n = core_pkg::S_FETCH;  // Adds, MOVI, unused codes
            end
            core_pkg::S_MEM:   if (ls_done) state_n = core_pkg::S_FETCH;
            default:           state_n = core_pkg::S_HALT;  // Stuck until reset
        endcase
    end

    assign fetch_busy_n = (fetch_busy | fetch_start) & ~instr_valid;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= core_pkg::S_FETCH;
            fetch_busy  <= 1'b0;
            fetch_start <= 1'b0;
            flags_q     <= '0;
        end
        else
        begin
            state       <= state_n;
            fetch_busy  <= fetch_busy_n;
            // One pulse per visit to FETCH
            fetch_start <= (state_n == core_pkg::S_FETCH) && !fetch_busy_n;
            if ((state == core_pkg::S_EXEC) && is_add)
                flags_q <= alu_flags;
        end
    end

    assign halted = (state == core_pkg::S_HALT);

    // Memory completions only while waiting on one
    a_done_in_mem: assert property (
        @(posedge clk) disable iff (!arst_n)
        ls_done |-> (state == core_pkg::S_MEM)
    );

endmodule

// ==== load_store.sv ====
`include "core_cfg.svh"

module load_store (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ls_start,
    input  logic                    ls_we,
    input  logic [`CORE_DATA_W-1:0] ls_addr,
    input  logic [`CORE_DATA_W-1:0] ls_wdata,
    output logic                    ls_req,
    output core_pkg::mem_req_t      ls_cmd,
    input  logic                    ls_gnt,
    input  logic                    ls_rvalid,
    input  logic [`CORE_DATA_W-1:0] rdata,
    output logic                    ls_done,
    output logic [`CORE_DATA_W-1:0] ls_rdata
);

    logic               req_q;
    core_pkg::mem_req_t cmd_q;

    // Request held until granted
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            req_q <= 1'b0;
        else if (ls_start)
            req_q <= 1'b1;
        else if (ls_gnt)
            req_q <= 1'b0;
    end

    // Command captured at start
    always_ff @(posedge clk)
    begin
        if (ls_start)
        begin
            cmd_q.addr  <= ls_addr;
            cmd_q.we    <= ls_we;
            cmd_q.wdata <= ls_wdata;
        end
    end

    assign ls_req = req_q;
    assign ls_cmd = cmd_q;

    // Store done at grant, load done at response
    assign ls_done  = (req_q & ls_gnt & cmd_q.we) | ls_rvalid;
    assign ls_rdata = rdata;

endmodule

// ==== instr_fetch.sv ====
`include "core_cfg.svh"

module instr_fetch (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fetch_start,   // One-cycle pulse from sequencer
    output logic                    fetch_req,
    output logic [`CORE_DATA_W-1:0] fetch_addr,
    input  logic                    fetch_gnt,
    input  logic                    fetch_rvalid,
    input  logic [`CORE_DATA_W-1:0] rdata,
    output logic                    instr_valid,
    output core_pkg::instr_t        instr
);

    logic [`CORE_DATA_W-1:0] pc;
    logic                    req_hold;   // Lost arbitration, keep asking

    // Request goes out in the start cycle itself
    assign fetch_req  = fetch_start | req_hold;
    assign fetch_addr = pc;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc          <= `CORE_RESET_PC;
            req_hold    <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            req_hold    <= fetch_req & ~fetch_gnt;
            instr_valid <= fetch_rvalid;          // Lands with captured word
            if (fetch_gnt)
                pc <= pc + 1'b1;                  // Word addressed
        end
    end

    // Instruction word held through EXEC and MEM
    always_ff @(posedge clk)
    begin
        if (fetch_rvalid)
            instr <= core_pkg::instr_t'(rdata);
    end

endmodule

// ==== mem_arbiter.sv ====
`include "core_cfg.svh"

module mem_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    // Fetch side reads only
    input  logic                    fetch_req,
    input  logic [`CORE_DATA_W-1:0] fetch_addr,
    output logic                    fetch_gnt,
    output logic                    fetch_rvalid,
    // Load/store side
    input  logic                    ls_req,
    input  core_pkg::mem_req_t      ls_cmd,
    output logic                    ls_gnt,
    output logic                    ls_rvalid,
    output logic [`CORE_DATA_W-1:0] rdata,      // Shared read data
    // External memory
    output logic                    mem_req,
    output core_pkg::mem_req_t      mem_out,
    input  logic [`CORE_DATA_W-1:0] mem_rdata,
    input  logic                    mem_rvalid
);

    logic rd_pending;   // Read strobe issued last cycle
    logic rd_owner_ls;  // Which unit owns that read

    // Load/store wins over fetch
    assign ls_gnt    = ls_req;
    assign fetch_gnt = fetch_req & ~ls_req;
    assign mem_req   = ls_req | fetch_req;
    assign mem_out   = ls_req ? ls_cmd
                              : core_pkg::mem_req_t'{addr: fetch_addr, we: 1'b0, wdata: '0};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_pending  <= 1'b0;
            rd_owner_ls <= 1'b0;
        end
        else
        begin
            rd_pending <= mem_req & ~mem_out.we;
            if (mem_req && !mem_out.we)
                rd_owner_ls <= ls_gnt;
        end
    end

    // Response routed to the owner of the read
    assign fetch_rvalid = mem_rvalid & rd_pending & ~rd_owner_ls;
    assign ls_rvalid    = mem_rvalid & rd_pending & rd_owner_ls;
    assign rdata        = mem_rdata;

    // Fetch request that lost keeps its request and address
    a_fetch_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fetch_req && !fetch_gnt) |=> (fetch_req && $stable(fetch_addr))
    );

    // No response without a read strobe the cycle before
    a_rvalid_after_read: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_rvalid |-> $past(mem_req && !mem_out.we)
    );

endmodule

// ==== reg_file.sv ====
`include "core_cfg.svh"

module reg_file (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [$clog2(`CORE_REG_N)-1:0]  ra_addr,
    input  logic [$clog2(`CORE_REG_N)-1:0]  rb_addr,
    output logic [`CORE_DATA_W-1:0]         ra_data,
    output logic [`CORE_DATA_W-1:0]         rb_data,
    input  logic                            we,
    input  logic [$clog2(`CORE_REG_N)-1:0]  w_addr,
    input  logic [`CORE_DATA_W-1:0]         w_data
);

    logic [`CORE_DATA_W-1:0] regs [`CORE_REG_N];

    // Single write port, all registers zero at reset
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CORE_REG_N; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[w_addr] <= w_data;
    end

    // Asynchronous reads
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

    // Write address must be resolved whenever a write is enabled
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        we |-> !$isunknown(w_addr)
    );

endmodule

// ==== alu.sv ====
`include "core_cfg.svh"

module alu (
    input  logic [`CORE_DATA_W-1:0] a,
    input  logic [`CORE_DATA_W-1:0] b,
    input  core_pkg::opcode_e       opcode,
    input  core_pkg::opext_e        opext,
    input  logic                    carry,     // Stored C from status reg
    output logic [`CORE_DATA_W-1:0] result,
    output core_pkg::flags_t        flags
);

    logic                  add_op;   // One of the six adds
    logic                  use_cin;  // ADDC forms only
    logic                  set_c;
    logic                  set_f;
    logic [`CORE_DATA_W:0] sum;      // Extra bit holds carry out
    logic                  ovf;

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        add_op  = 1'b1;
        use_cin = 1'b0;
        set_c   = 1'b0;
        set_f   = 1'b0;
        case (opcode)
            core_pkg::OP_ADDGRP:
            begin
                case (opext)
                    core_pkg::EXT_ADD:  set_f = 1'b1;   // Signed
                    core_pkg::EXT_ADDU: set_c = 1'b1;   // Unsigned
                    core_pkg::EXT_ADDC:
                    begin
                        use_cin = 1'b1;
                        set_c   = 1'b1;
                        set_f   = 1'b1;
                    end
                    default: add_op = 1'b0;             // WAIT, unused codes
                endcase
            end
            core_pkg::OP_ADDI:  set_f = 1'b1;           // Ext ignored in imm form
            core_pkg::OP_ADDUI: set_c = 1'b1;
            core_pkg::OP_ADDCI:
            begin
                use_cin = 1'b1;
                set_c   = 1'b1;
                set_f   = 1'b1;
            end
            default: add_op = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Adder and flags
    ////////////////////////////////////////////////////////////

    assign sum = {1'b0, a} + {1'b0, b} + {{`CORE_DATA_W{1'b0}}, use_cin & carry};

    // Like-signed operands, sum sign flipped
    assign ovf = (a[`CORE_DATA_W-1] == b[`CORE_DATA_W-1])
              && (sum[`CORE_DATA_W-1] != a[`CORE_DATA_W-1]);

    always_comb
    begin
        result = '0;
        flags  = '0;                                    // L, N stay low
        if (add_op)
        begin
            result  = sum[`CORE_DATA_W-1:0];
            flags.c = set_c & sum[`CORE_DATA_W];
            flags.f = set_f & ovf;
            flags.z = (sum[`CORE_DATA_W-1:0] == '0);
        end
    end

endmodule

// ==== core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////

    // Major opcode, instr[15:12]
    typedef enum logic [3:0] {
        OP_ADDGRP   = 4'b0000,  // Register adds and WAIT
        OP_LOADSTOR = 4'b0100,
        OP_ADDI     = 4'b0101,
        OP_ADDUI    = 4'b0110,
        OP_MOVI     = 4'b1101,
        OP_ADDCI    = 4'b1110
    } opcode_e;

    // Opcode extension, instr[7:4]
    typedef enum logic [3:0] {
        EXT_WAIT = 4'b0000,
        EXT_STOR = 4'b0100,
        EXT_ADD  = 4'b0101,
        EXT_ADDU = 4'b0110,
        EXT_ADDC = 4'b0111
    } opext_e;

    // LOAD reuses the WAIT code under OP_LOADSTOR
    localparam opext_e EXT_LOAD = EXT_WAIT;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rdest;
        opext_e     opext;      // Upper imm nibble in immediate form
        logic [3:0] rsrc;       // Lower imm nibble
    } instr_t;

    // Same order as CLFZN, C is the top bit
    typedef struct packed {
        logic c;                // Carry out
        logic l;
        logic f;                // Signed overflow
        logic z;                // Zero result
        logic n;
    } flags_t;

    ////////////////////////////////////////////////////////////
    // Memory port and sequencer
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`CORE_DATA_W-1:0] addr;
        logic                    we;      // 1 = write
        logic [`CORE_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } ctrl_state_e;

endpackage

// ==== core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

////////////////////////////////////////////////////////////
// Core dimensions
////////////////////////////////////////////////////////////

// Data path and address width
`define CORE_DATA_W 16

// Registers in the register file
`define CORE_REG_N 16

// Immediate field, instr[7:0]
`define CORE_IMM_W 8

// First fetch address out of reset
`define CORE_RESET_PC 16'h0000

`endif
